// ==== common/mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] Word;
	typedef logic [4:0] RegAddr;

	typedef enum logic [5:0] {
		OpRType = 6'h00,
		OpJ = 6'h02,
		OpJal = 6'h03,
		OpBeq = 6'h04,
		OpAddi = 6'h08,
		OpOri = 6'h0d,
		OpLw = 6'h23,
		OpSw = 6'h2b
	} Opcode;

	typedef enum logic [5:0] {
		FunctSll = 6'h00,
		FunctSrl = 6'h02,
		FunctAdd = 6'h20,
		FunctSub = 6'h22,
		FunctAnd = 6'h24,
		FunctOr = 6'h25,
		FunctSlt = 6'h2a
	} Funct;

	typedef struct packed {
		Opcode opcode;
		RegAddr rs;
		RegAddr rt;
		RegAddr rd;
		logic [4:0] shamt;
		Funct funct;
	} RFormat;

	typedef struct packed {
		Opcode opcode;
		RegAddr rs;
		RegAddr rt;
		logic [15:0] immediate;
	} IFormat;

	typedef struct packed {
		Opcode opcode;
		logic [25:0] target;
	} JFormat;

	typedef union packed {
		RFormat rFormat;
		IFormat iFormat;
		JFormat jFormat;
	} Instruction;

	typedef enum logic [1:0] {Port1Rs, Port1Rt, Port1None} Port1AddrSource;
	typedef enum logic [1:0] {Port2Rs, Port2Rt, Port2None} Port2AddrSource;
	typedef enum logic [1:0] {WriteAddrRd, WriteAddrRt, WriteAddrR31, WriteAddrNone} WriteAddrSource;
	typedef enum logic [1:0] {WriteDataMemory, WriteDataPc, WriteDataAlu} WriteDataSource;

	typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluSll, AluSrl} AluOp;
	typedef enum logic [1:0] {AluBRegister, AluBSignImm, AluBZeroImm} AluBSource;
	typedef enum logic [1:0] {PcNext, PcBranch, PcJump} PcSource;

	typedef struct packed {
		Port1AddrSource port1AddrSource;
		Port2AddrSource port2AddrSource;
		WriteAddrSource writeAddrSource;
		WriteDataSource writeDataSource;
		logic writeEnable;
	} RegisterControl;

	typedef struct packed {
		RegisterControl registerControl;
		AluOp aluOp;
		AluBSource aluBSource;
		PcSource pcSource;
		logic ramWrite;
		logic isBranch;
	} Control;

endpackage

// ==== hw/mipsControl.sv ====
`timescale 1ns/1ps

module mipsControl (
	input mipsPkg::Instruction instruction,
	output mipsPkg::Control control
);

	localparam mipsPkg::Control noOperation = '{
		registerControl: '{
			port1AddrSource: mipsPkg::Port1None,
			port2AddrSource: mipsPkg::Port2None,
			writeAddrSource: mipsPkg::WriteAddrNone,
			writeDataSource: mipsPkg::WriteDataAlu,
			writeEnable: 1'b0
		},
		aluOp: mipsPkg::AluAdd,
		aluBSource: mipsPkg::AluBRegister,
		pcSource: mipsPkg::PcNext,
		ramWrite: 1'b0,
		isBranch: 1'b0
	};

	always_comb begin
		control = noOperation;
		case (instruction.rFormat.opcode)
			mipsPkg::OpRType: begin
				control.registerControl.port1AddrSource = mipsPkg::Port1Rs;
				control.registerControl.port2AddrSource = mipsPkg::Port2Rt;
				control.registerControl.writeAddrSource = mipsPkg::WriteAddrRd;
				control.registerControl.writeEnable = 1'b1;
				case (instruction.rFormat.funct)
					mipsPkg::FunctAdd: control.aluOp = mipsPkg::AluAdd;
					mipsPkg::FunctSub: control.aluOp = mipsPkg::AluSub;
					mipsPkg::FunctAnd: control.aluOp = mipsPkg::AluAnd;
					mipsPkg::FunctOr: control.aluOp = mipsPkg::AluOr;
					mipsPkg::FunctSlt: control.aluOp = mipsPkg::AluSlt;
					mipsPkg::FunctSll: control.aluOp = mipsPkg::AluSll;
					mipsPkg::FunctSrl: control.aluOp = mipsPkg::AluSrl;
					default: control = noOperation; // unknown funct
				endcase
			end
			mipsPkg::OpAddi, mipsPkg::OpOri, mipsPkg::OpLw: begin
				control.registerControl.port1AddrSource = mipsPkg::Port1Rs;
				control.registerControl.writeAddrSource = mipsPkg::WriteAddrRt;
				control.registerControl.writeEnable = 1'b1;
				control.aluBSource = mipsPkg::AluBSignImm;
				if (instruction.iFormat.opcode == mipsPkg::OpOri) begin
					control.aluOp = mipsPkg::AluOr;
					control.aluBSource = mipsPkg::AluBZeroImm; // ori zero-extends
				end
				if (instruction.iFormat.opcode == mipsPkg::OpLw)
					control.registerControl.writeDataSource = mipsPkg::WriteDataMemory;
			end
			mipsPkg::OpSw: begin
				control.registerControl.port1AddrSource = mipsPkg::Port1Rs;
				control.registerControl.port2AddrSource = mipsPkg::Port2Rt; // store data
				control.aluBSource = mipsPkg::AluBSignImm;
				control.ramWrite = 1'b1;
			end
			mipsPkg::OpBeq: begin
				control.registerControl.port1AddrSource = mipsPkg::Port1Rs;
				control.registerControl.port2AddrSource = mipsPkg::Port2Rt;
				control.aluOp = mipsPkg::AluSub; // equal when difference is zero
				control.pcSource = mipsPkg::PcBranch;
				control.isBranch = 1'b1;
			end
			mipsPkg::OpJ: control.pcSource = mipsPkg::PcJump;
			mipsPkg::OpJal: begin
				control.registerControl.writeAddrSource = mipsPkg::WriteAddrR31;
				control.registerControl.writeDataSource = mipsPkg::WriteDataPc;
				control.registerControl.writeEnable = 1'b1;
				control.pcSource = mipsPkg::PcJump;
			end
			default: control = noOperation;
		endcase
	end

	always_comb begin
		assert #0 (!(control.registerControl.writeEnable && control.ramWrite))
			else $error("register write and memory write decoded together");
	end

endmodule

// ==== register/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic clock,
	input logic reset,
	input mipsPkg::RegAddr rd1Addr,
	input mipsPkg::RegAddr rd2Addr,
	input mipsPkg::RegAddr wrAddr,
	input mipsPkg::Word wrData,
	input logic wrEnable,
	output mipsPkg::Word rd1Data,
	output mipsPkg::Word rd2Data
);

	mipsPkg::Word regs [32];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEnable && wrAddr != 5'd0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// old value is seen when reading the register being written
	assign rd1Data = (rd1Addr == 5'd0) ? '0 : regs[rd1Addr];
	assign rd2Data = (rd2Addr == 5'd0) ? '0 : regs[rd2Addr];

	zeroAfterWrite: assert property (
		@(posedge clock) disable iff (reset) wrEnable |=> regs[0] == '0
	) else $error("register zero changed after a write");

endmodule

// ==== register/registerDatapath.sv ====
`timescale 1ns/1ps

module registerDatapath (
	input logic clock,
	input logic reset,
	input mipsPkg::RegisterControl control,
	input mipsPkg::Word pcAddr,
	input mipsPkg::Word ramOut,
	input mipsPkg::Word aluResult,
	input mipsPkg::Instruction instruction,
	output mipsPkg::Word port1,
	output mipsPkg::Word port2
);

	mipsPkg::RegAddr rd1Addr;
	mipsPkg::RegAddr rd2Addr;
	mipsPkg::RegAddr wrAddr;
	mipsPkg::Word wrData;

	registerFile u_registerFile (
		.clock(clock),
		.reset(reset),
		.rd1Addr(rd1Addr),
		.rd2Addr(rd2Addr),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.wrEnable(control.writeEnable),
		.rd1Data(port1),
		.rd2Data(port2)
	);

	always_comb begin
		case (control.port1AddrSource)
			mipsPkg::Port1Rs: rd1Addr = instruction.rFormat.rs;
			mipsPkg::Port1Rt: rd1Addr = instruction.rFormat.rt;
			default: rd1Addr = 5'd0;
		endcase
	end

	always_comb begin
		case (control.port2AddrSource)
			mipsPkg::Port2Rs: rd2Addr = instruction.rFormat.rs;
			mipsPkg::Port2Rt: rd2Addr = instruction.rFormat.rt;
			default: rd2Addr = 5'd0;
		endcase
	end

	always_comb begin
		case (control.writeAddrSource)
			mipsPkg::WriteAddrRd: wrAddr = instruction.rFormat.rd;
			mipsPkg::WriteAddrRt: wrAddr = instruction.rFormat.rt;
			mipsPkg::WriteAddrR31: wrAddr = 5'd31; // link register
			default: wrAddr = 5'd0;
		endcase
	end

	always_comb begin
		case (control.writeDataSource)
			mipsPkg::WriteDataMemory: wrData = ramOut;
			mipsPkg::WriteDataPc: wrData = pcAddr + 32'd4; // return address
			default: wrData = aluResult;
		endcase
	end

endmodule

// ==== hw/aluDatapath.sv ====
`timescale 1ns/1ps

module aluDatapath (
	input mipsPkg::Control control,
	input mipsPkg::Instruction instruction,
	input mipsPkg::Word port1,
	input mipsPkg::Word port2,
	output mipsPkg::Word aluResult,
	output logic zero
);

	mipsPkg::Word operandB;
	logic [15:0] immediate;
	logic [4:0] shamt;

	assign immediate = instruction.iFormat.immediate;
	assign shamt = instruction.rFormat.shamt;

	always_comb begin
		case (control.aluBSource)
			mipsPkg::AluBSignImm: operandB = {{16{immediate[15]}}, immediate};
			mipsPkg::AluBZeroImm: operandB = {16'd0, immediate};
			default: operandB = port2;
		endcase
	end

	always_comb begin
		case (control.aluOp)
			mipsPkg::AluAdd: aluResult = port1 + operandB;
			mipsPkg::AluSub: aluResult = port1 - operandB;
			mipsPkg::AluAnd: aluResult = port1 & operandB;
			mipsPkg::AluOr: aluResult = port1 | operandB;
			mipsPkg::AluSlt: aluResult = {31'd0, $signed(port1) < $signed(operandB)};
			mipsPkg::AluSll: aluResult = operandB << shamt; // shifts act on rt
			mipsPkg::AluSrl: aluResult = operandB >> shamt;
			default: aluResult = port1 + operandB;
		endcase
	end

	assign zero = (aluResult == '0);

endmodule

// ==== hw/pcDatapath.sv ====
`timescale 1ns/1ps

module pcDatapath #(
	parameter mipsPkg::Word resetAddress = 32'h0
) (
	input logic clock,
	input logic reset,
	input mipsPkg::Control control,
	input mipsPkg::Instruction instruction,
	input logic zero,
	output mipsPkg::Word pcAddr
);

	mipsPkg::Word pcPlus4;
	mipsPkg::Word branchTarget;
	mipsPkg::Word jumpTarget;
	mipsPkg::Word nextPc;

	assign pcPlus4 = pcAddr + 32'd4;
	assign branchTarget = pcPlus4 + {{14{instruction.iFormat.immediate[15]}},
		instruction.iFormat.immediate, 2'b00};
	assign jumpTarget = {pcPlus4[31:28], instruction.jFormat.target, 2'b00};

	always_comb begin
		case (control.pcSource)
			mipsPkg::PcBranch: nextPc = (control.isBranch && zero) ? branchTarget : pcPlus4;
			mipsPkg::PcJump: nextPc = jumpTarget;
			default: nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			pcAddr <= resetAddress;
		else
			pcAddr <= nextPc;
	end

	pcAligned: assert property (
		@(posedge clock) disable iff (reset) pcAddr[1:0] == 2'b00
	) else $error("pc lost word alignment");

endmodule

// ==== hw/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore #(
	parameter mipsPkg::Word resetAddress = 32'h0
) (
	input logic clock,
	input logic reset,
	input mipsPkg::Word instruction,
	input mipsPkg::Word ramOut,
	output mipsPkg::Word pcAddr,
	output mipsPkg::Word ramAddr,
	output mipsPkg::Word ramWriteData,
	output logic ramWrite
);

	mipsPkg::Instruction decoded;
	mipsPkg::Control control;
	mipsPkg::Word port1;
	mipsPkg::Word port2;
	mipsPkg::Word aluResult;
	logic zero;

	assign decoded = instruction;
	assign ramAddr = aluResult;
	assign ramWriteData = port2;
	assign ramWrite = control.ramWrite && !reset; // no stores while in reset

	mipsControl u_mipsControl (
		.instruction(decoded),
		.control(control)
	);

	registerDatapath u_registerDatapath (
		.clock(clock),
		.reset(reset),
		.control(control.registerControl),
		.pcAddr(pcAddr),
		.ramOut(ramOut),
		.aluResult(aluResult),
		.instruction(decoded),
		.port1(port1),
		.port2(port2)
	);

	aluDatapath u_aluDatapath (
		.control(control),
		.instruction(decoded),
		.port1(port1),
		.port2(port2),
		.aluResult(aluResult),
		.zero(zero)
	);

	pcDatapath #(.resetAddress(resetAddress)) u_pcDatapath (
		.clock(clock),
		.reset(reset),
		.control(control),
		.instruction(decoded),
		.zero(zero),
		.pcAddr(pcAddr)
	);

endmodule

// ==== testbench/memoryModel.sv ====
`timescale 1ns/1ps

module memoryModel (
	input logic clock,
	input mipsPkg::Word pcAddr,
	input mipsPkg::Word ramAddr,
	input mipsPkg::Word ramWriteData,
	input logic ramWrite,
	output mipsPkg::Word instruction,
	output mipsPkg::Word ramOut
);

	mipsPkg::Word rom [64]; // filled by the testbench
	mipsPkg::Word ram [256];
	mipsPkg::Word storeAddrLog [$];
	mipsPkg::Word storeDataLog [$];

	initial begin
		for (int i = 0; i < 256; i++)
			ram[i] = 32'h5a5a0000 ^ (i << 2); // each word carries its own address
	end

	assign instruction = rom[pcAddr[7:2]];
	assign ramOut = ram[ramAddr[9:2]];

	always @(posedge clock) begin
		if (ramWrite) begin
			ram[ramAddr[9:2]] <= ramWriteData;
			storeAddrLog.push_back(ramAddr);
			storeDataLog.push_back(ramWriteData);
		end
	end

	function automatic int storeCount(mipsPkg::Word addr);
		int count;
		count = 0;
		foreach (storeAddrLog[i])
			if (storeAddrLog[i] == addr)
				count++;
		return count;
	endfunction

	// latest value logged for this address, X when never stored
	function automatic mipsPkg::Word storedValue(mipsPkg::Word addr);
		mipsPkg::Word value;
		value = 'x;
		foreach (storeAddrLog[i])
			if (storeAddrLog[i] == addr)
				value = storeDataLog[i];
		return value;
	endfunction

endmodule

// ==== testbench/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb;

	localparam int TestCount = 6;
	localparam int TimeoutCycles = 100;
	localparam mipsPkg::Word AddrArith = 32'h100; // seven results, one word apart
	localparam mipsPkg::Word AddrStore1 = 32'h120;
	localparam mipsPkg::Word AddrStore2 = 32'h124;
	localparam mipsPkg::Word AddrTaken = 32'h130;
	localparam mipsPkg::Word AddrSkipped = 32'h134;
	localparam mipsPkg::Word AddrFall = 32'h138;
	localparam mipsPkg::Word AddrLink = 32'h140;
	localparam mipsPkg::Word AddrJumpSkipped = 32'h144;
	localparam mipsPkg::Word AddrZero = 32'h148;
	localparam mipsPkg::Word BranchPc = 32'd76; // word 19, the taken beq
	localparam logic [15:0] BranchOffset = 16'd1;
	localparam mipsPkg::Word BranchTarget = BranchPc + 32'd4 + (32'(BranchOffset) << 2);
	localparam mipsPkg::Word JalPc = 32'd96; // word 24
	localparam logic [25:0] JalTarget = 26'd26;

	logic clock;
	logic reset;
	mipsPkg::Word instruction;
	mipsPkg::Word ramOut;
	mipsPkg::Word pcAddr;
	mipsPkg::Word ramAddr;
	mipsPkg::Word ramWriteData;
	logic ramWrite;

	logic [15:0] constA;
	logic [15:0] constB;
	logic [4:0] shiftLeft;
	logic [4:0] shiftRight;
	mipsPkg::Word operandA;
	mipsPkg::Word operandB;
	mipsPkg::Word expArith [7];
	int failures [TestCount];
	logic timedOut;
	string testNames [TestCount] = '{"reset", "arithmetic", "loadStore", "branch",
		"jumpLink", "registerZero"};
	string arithNames [7] = '{"add", "sub", "and", "or", "slt", "sll", "srl"};
	mipsPkg::Word testEndPc [TestCount] = '{32'd12, 32'd64, 32'd76, 32'd96, 32'd108, 32'd116};

	mipsCore #(.resetAddress(32'h0)) u_mipsCore (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.ramOut(ramOut),
		.pcAddr(pcAddr),
		.ramAddr(ramAddr),
		.ramWriteData(ramWriteData),
		.ramWrite(ramWrite)
	);

	memoryModel u_memoryModel (
		.clock(clock),
		.pcAddr(pcAddr),
		.ramAddr(ramAddr),
		.ramWriteData(ramWriteData),
		.ramWrite(ramWrite),
		.instruction(instruction),
		.ramOut(ramOut)
	);

	always #20 clock = ~clock;

	task automatic valueMismatch(int test, string what, mipsPkg::Word expected,
		mipsPkg::Word actual);
		failures[test]++;
		$display("ERROR %s (%s): expected %h, actual %h", testNames[test], what,
			expected, actual);
	endtask

	task automatic noteFailure(int test, string what);
		failures[test]++;
		$display("%s: %s", testNames[test], what);
	endtask

	property storesValue(mipsPkg::Word addr, mipsPkg::Word expected);
		@(posedge clock) disable iff (reset)
			(ramWrite && ramAddr == addr) |-> ramWriteData == expected;
	endproperty

	resetPcCheck: assert property (@(negedge clock) reset |-> pcAddr == 32'd0)
		else valueMismatch(0, "pc in reset", 32'd0, $sampled(pcAddr));
	resetStrobeCheck: assert property (@(negedge clock) reset |-> !ramWrite)
		else noteFailure(0, "memory write strobe was high during reset");
	releaseCheck: assert property (@(posedge clock) $fell(reset) |->
		(pcAddr == 32'd0 && !ramWrite) ##1 pcAddr == 32'd4 ##1 pcAddr == 32'd8)
		else noteFailure(0, "fetch sequence after reset did not run 0, 4, 8");

	for (genvar k = 0; k < 7; k++) begin : arithChecks
		resultCheck: assert property (storesValue(AddrArith + 4 * k, expArith[k]))
			else valueMismatch(1, arithNames[k], expArith[k], $sampled(ramWriteData));
	end

	store1Check: assert property (storesValue(AddrStore1, operandA))
		else valueMismatch(2, "first store", operandA, $sampled(ramWriteData));
	store2Check: assert property (storesValue(AddrStore2, operandA))
		else valueMismatch(2, "reloaded store", operandA, $sampled(ramWriteData));
	takenCheck: assert property (storesValue(AddrTaken, operandA))
		else valueMismatch(3, "taken marker", operandA, $sampled(ramWriteData));
	fallCheck: assert property (storesValue(AddrFall, operandA))
		else valueMismatch(3, "fall-through marker", operandA, $sampled(ramWriteData));
	skippedCheck: assert property (@(posedge clock) disable iff (reset)
		ramWrite |-> ramAddr != AddrSkipped)
		else noteFailure(3, "the instruction skipped by the taken beq stored anyway");
	branchPcCheck: assert property (@(posedge clock) disable iff (reset)
		pcAddr == BranchPc |=> pcAddr == BranchTarget)
		else valueMismatch(3, "pc after taken beq", BranchTarget, $sampled(pcAddr));
	linkCheck: assert property (storesValue(AddrLink, JalPc + 32'd4))
		else valueMismatch(4, "link register", JalPc + 32'd4, $sampled(ramWriteData));
	jumpSkippedCheck: assert property (@(posedge clock) disable iff (reset)
		ramWrite |-> ramAddr != AddrJumpSkipped)
		else noteFailure(4, "the instruction after jal stored anyway");
	jumpPcCheck: assert property (@(posedge clock) disable iff (reset)
		pcAddr == JalPc |=> pcAddr == {4'd0, JalTarget, 2'b00})
		else valueMismatch(4, "pc after jal", {4'd0, JalTarget, 2'b00}, $sampled(pcAddr));
	zeroCheck: assert property (storesValue(AddrZero, 32'd0))
		else valueMismatch(5, "register zero", 32'd0, $sampled(ramWriteData));

	function automatic mipsPkg::Word encodeR(logic [5:0] funct, mipsPkg::RegAddr rs,
		mipsPkg::RegAddr rt, mipsPkg::RegAddr rd, logic [4:0] shamt);
		return {6'h00, rs, rt, rd, shamt, funct};
	endfunction

	function automatic mipsPkg::Word encodeI(logic [5:0] opcode, mipsPkg::RegAddr rs,
		mipsPkg::RegAddr rt, logic [15:0] immediate);
		return {opcode, rs, rt, immediate};
	endfunction

	function automatic mipsPkg::Word encodeJ(logic [5:0] opcode, logic [25:0] target);
		return {opcode, target};
	endfunction

	task automatic place(int index, mipsPkg::Word word);
		u_memoryModel.rom[index] = word;
	endtask

	task automatic assembleProgram();
		for (int i = 0; i < 64; i++)
			place(i, encodeJ(mipsPkg::OpJ, 26'(i))); // stray fetches park on a jump-to-self
		place(0, encodeI(mipsPkg::OpAddi, 5'd0, 5'd1, constA));
		place(1, encodeI(mipsPkg::OpOri, 5'd0, 5'd2, constB));
		place(2, encodeR(mipsPkg::FunctAdd, 5'd1, 5'd2, 5'd3, 5'd0));
		place(4, encodeR(mipsPkg::FunctSub, 5'd1, 5'd2, 5'd3, 5'd0));
		place(6, encodeR(mipsPkg::FunctAnd, 5'd1, 5'd2, 5'd3, 5'd0));
		place(8, encodeR(mipsPkg::FunctOr, 5'd1, 5'd2, 5'd3, 5'd0));
		place(10, encodeR(mipsPkg::FunctSlt, 5'd1, 5'd2, 5'd3, 5'd0));
		place(12, encodeR(mipsPkg::FunctSll, 5'd0, 5'd1, 5'd3, shiftLeft));
		place(14, encodeR(mipsPkg::FunctSrl, 5'd0, 5'd1, 5'd3, shiftRight));
		for (int k = 0; k < 7; k++)
			place(3 + 2 * k, encodeI(mipsPkg::OpSw, 5'd0, 5'd3, AddrArith[15:0] + 16'(4 * k)));
		place(16, encodeI(mipsPkg::OpSw, 5'd0, 5'd1, AddrStore1[15:0]));
		place(17, encodeI(mipsPkg::OpLw, 5'd0, 5'd4, AddrStore1[15:0]));
		place(18, encodeI(mipsPkg::OpSw, 5'd0, 5'd4, AddrStore2[15:0]));
		place(19, encodeI(mipsPkg::OpBeq, 5'd1, 5'd1, BranchOffset));
		place(20, encodeI(mipsPkg::OpSw, 5'd0, 5'd1, AddrSkipped[15:0]));
		place(21, encodeI(mipsPkg::OpSw, 5'd0, 5'd1, AddrTaken[15:0]));
		place(22, encodeI(mipsPkg::OpBeq, 5'd1, 5'd2, BranchOffset));
		place(23, encodeI(mipsPkg::OpSw, 5'd0, 5'd1, AddrFall[15:0]));
		place(24, encodeJ(mipsPkg::OpJal, JalTarget));
		place(25, encodeI(mipsPkg::OpSw, 5'd0, 5'd1, AddrJumpSkipped[15:0]));
		place(26, encodeI(mipsPkg::OpSw, 5'd0, 5'd31, AddrLink[15:0]));
		place(27, encodeI(mipsPkg::OpAddi, 5'd0, 5'd0, constA));
		place(28, encodeI(mipsPkg::OpSw, 5'd0, 5'd0, AddrZero[15:0]));
		// word 29 keeps its jump-to-self and ends the program
	endtask

	task automatic expectStore(int test, mipsPkg::Word addr, mipsPkg::Word expected);
		int count;
		mipsPkg::Word value;
		count = u_memoryModel.storeCount(addr);
		value = u_memoryModel.storedValue(addr);
		if (count != 1)
			noteFailure(test, $sformatf("store to %h seen %0d times instead of once",
				addr, count));
		else if (value !== expected)
			valueMismatch(test, $sformatf("logged store to %h", addr), expected, value);
	endtask

	task automatic checkStoresSeen(int test);
		case (test)
			1: begin
				for (int k = 0; k < 7; k++)
					expectStore(test, AddrArith + 32'(4 * k), expArith[k]);
			end
			2: begin
				expectStore(test, AddrStore1, operandA);
				expectStore(test, AddrStore2, operandA);
			end
			3: begin
				expectStore(test, AddrTaken, operandA);
				expectStore(test, AddrFall, operandA);
			end
			4: expectStore(test, AddrLink, JalPc + 32'd4);
			5: expectStore(test, AddrZero, 32'd0);
			default: ;
		endcase
	endtask

	task automatic waitForPc(mipsPkg::Word target, output logic expired);
		int cycles;
		cycles = 0;
		expired = 1'b0;
		while (pcAddr !== target && !expired) begin
			@(negedge clock);
			cycles++;
			if (cycles > TimeoutCycles)
				expired = 1'b1;
		end
	endtask

	initial begin
		int passed;
		passed = 0;
		clock = 1'b0;
		reset = 1'b1;
		timedOut = 1'b0;
		void'($urandom(32'hcf29));
		constA = 16'($urandom());
		constB = 16'($urandom());
		if (constA == 16'd0)
			constA = 16'h1; // register zero test needs a nonzero write
		if (constB == constA && !constA[15])
			constB = constB ^ 16'h1; // second beq needs unequal registers
		shiftLeft = 5'($urandom());
		shiftRight = 5'($urandom());
		operandA = {{16{constA[15]}}, constA}; // addi sign-extends
		operandB = {16'd0, constB}; // ori zero-extends
		expArith[0] = operandA + operandB;
		expArith[1] = operandA - operandB;
		expArith[2] = operandA & operandB;
		expArith[3] = operandA | operandB;
		expArith[4] = ($signed(operandA) < $signed(operandB)) ? 32'd1 : 32'd0;
		expArith[5] = operandA << shiftLeft;
		expArith[6] = operandA >> shiftRight;
		foreach (failures[t])
			failures[t] = 0;
		assembleProgram();
		repeat (10) @(negedge clock);
		reset = 1'b0;
		for (int t = 0; t < TestCount; t++) begin
			if (!timedOut) begin
				waitForPc(testEndPc[t], timedOut);
				if (timedOut) begin
					$display("timeout: pc never reached %h in test %s", testEndPc[t],
						testNames[t]);
				end else begin
					checkStoresSeen(t);
					if (failures[t] == 0)
						passed++;
					$display("test %s: %s, %0d errors", testNames[t],
						(failures[t] == 0) ? "pass" : "fail", failures[t]);
				end
			end
		end
		$display("%0d tests passed, %0d failed", passed, TestCount - passed);
		if (passed == TestCount && !timedOut)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== list.f ====
common/mipsPkg.sv
hw/mipsControl.sv
register/registerFile.sv
register/registerDatapath.sv
hw/aluDatapath.sv
hw/pcDatapath.sv
hw/mipsCore.sv
testbench/memoryModel.sv
testbench/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mips_core

sources:
  - common/mipsPkg.sv
  - hw/mipsControl.sv
  - register/registerFile.sv
  - register/registerDatapath.sv
  - hw/aluDatapath.sv
  - hw/pcDatapath.sv
  - hw/mipsCore.sv
  - target: test
    files:
      - testbench/memoryModel.sv
      - testbench/mipsCoreTb.sv
